// ==== compile.f ====
source/regbank_pkg.sv
source/bank_port_if.sv
source/regfile_1r1w.sv
source/bank_dispatch.sv
source/read_collect.sv
source/regbank_top.sv
testbench/tb_regbank.sv

// ==== Bender.yml ====
package:
  name: regbank

sources:
  - source/regbank_pkg.sv
  - source/bank_port_if.sv
  - source/regfile_1r1w.sv
  - source/bank_dispatch.sv
  - source/read_collect.sv
  - source/regbank_top.sv
  - target: test
    files:
      - testbench/tb_regbank.sv

// ==== testbench/tb_regbank.sv ====
// Self-checking testbench for the banked register store, compiled with the sources in compile.f
`timescale 1ns/1ps
`default_nettype none

module tb_regbank;

	localparam int NUM_BANKS = 4;
	localparam int BANK_DEPTH = 8;
	localparam int REQ_DEPTH = 4;
	localparam int RSP_DEPTH = 4;
	localparam int RSP_CREDITS = 2;
	localparam int MEM_WORDS = NUM_BANKS * BANK_DEPTH;
	localparam int TIMEOUT = 500;
	// Enough reads to fill downstream credits, collector queue and request FIFO
	localparam int STALL_READS = RSP_CREDITS + RSP_DEPTH + REQ_DEPTH;

	logic clk;
	logic rstnn;
	logic req_valid;
	logic req_write;
	regbank_pkg::addr_t req_addr;
	regbank_pkg::data_t req_wdata;
	regbank_pkg::permit_t req_permit;
	wire req_credit;
	wire rsp_valid;
	wire regbank_pkg::data_t rsp_data;
	logic rsp_credit;

	integer seed;
	// Reference memory, indexed directly by request address
	regbank_pkg::data_t model_mem [MEM_WORDS];
	regbank_pkg::data_t exp_q [$];
	int up_credits;
	// Responses received but not yet credited back
	int owed;
	int rsp_seen;
	logic consumer_on;

	regbank_top u_regbank_top (
		.clk(clk),
		.rstnn(rstnn),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_permit(req_permit),
		.req_credit(req_credit),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.rsp_credit(rsp_credit)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	// **************************************************
	// Checking helpers
	// **************************************************

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			fail_run($sformatf("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected));
	endtask

	// **************************************************
	// Request driver
	// **************************************************

	// Entered 2 ns after a rising edge, returns at the same phase
	task automatic send_req(input logic write, input regbank_pkg::addr_t addr,
		input regbank_pkg::data_t wdata, input regbank_pkg::permit_t permit);
		int waited;
		waited = 0;
		// Hold off while no upstream credit is left
		while (up_credits == 0)
		begin
			req_valid = 1'b0;
			@(posedge clk);
			#2;
			waited++;
			if (waited > TIMEOUT)
				fail_run("Timed out waiting for a request credit from the DUT");
		end
		req_valid = 1'b1;
		req_write = write;
		req_addr = addr;
		req_wdata = wdata;
		req_permit = permit;
		up_credits--;
		// Model follows request order
		if (write)
		begin
			for (int b = 0; b < regbank_pkg::PERMIT_W; b++)
			begin
				if (permit[b])
					model_mem[addr][b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
		else
		begin
			exp_q.push_back(model_mem[addr]);
		end
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	// Waits until every read has answered and every credit is back
	task automatic wait_drain(input string what);
		int waited;
		waited = 0;
		while ((exp_q.size() != 0) || (up_credits != REQ_DEPTH) || (owed != 0))
		begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > TIMEOUT)
				fail_run($sformatf("Timed out waiting for %s to drain", what));
		end
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	function automatic regbank_pkg::addr_t rand_addr();
		logic [31:0] r;
		r = $random(seed);
		return regbank_pkg::addr_t'(r % MEM_WORDS);
	endfunction

	// **************************************************
	// Monitor and consumer
	// **************************************************

	// Outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (rstnn)
		begin
			if (req_credit)
				up_credits++;
			if (up_credits > REQ_DEPTH)
				fail_run("The DUT returned more request credits than requests sent");
			if (rsp_valid)
			begin
				if (exp_q.size() == 0)
					fail_run("A response arrived with no read outstanding");
				else
					check_value("rsp_data", rsp_data, exp_q.pop_front());
				rsp_seen++;
				owed++;
			end
		end
	end

	// Random credit return, decided at the edge and driven after it
	always @(posedge clk)
	begin
		logic [31:0] r;
		logic give;
		r = $random(seed);
		give = consumer_on && (owed > 0) && (r[1:0] == 2'b00);
		if (give)
			owed--;
		#2;
		rsp_credit = give;
	end

	// **************************************************
	// Test sequence
	// **************************************************

	initial
	begin
		regbank_pkg::addr_t a;
		regbank_pkg::data_t d;
		logic [31:0] r;
		int base;
		seed = 32'h87b0_8c07;
		rstnn = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_permit = '0;
		rsp_credit = 1'b0;
		consumer_on = 1'b1;
		up_credits = REQ_DEPTH;
		owed = 0;
		rsp_seen = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = '0;
		repeat (4) @(posedge clk);
		#2;
		rstnn = 1'b1;

		// Every entry reads zero out of reset
		for (int i = 0; i < MEM_WORDS; i++)
			send_req(1'b0, regbank_pkg::addr_t'(i), '0, '0);
		wait_drain("reset-state reads");

		// Full-word write followed directly by a read
		for (int i = 0; i < 8; i++)
		begin
			a = rand_addr();
			d = $random(seed);
			send_req(1'b1, a, d, 4'hf);
			send_req(1'b0, a, '0, '0);
		end
		wait_drain("full-word writes");

		// Random permits merge into the old word
		for (int i = 0; i < 16; i++)
		begin
			a = rand_addr();
			d = $random(seed);
			r = $random(seed);
			send_req(1'b1, a, d, regbank_pkg::permit_t'(r));
			send_req(1'b0, a, '0, '0);
		end
		wait_drain("partial-permit writes");

		// Mixed traffic over all banks
		for (int i = 0; i < 200; i++)
		begin
			r = $random(seed);
			a = rand_addr();
			d = $random(seed);
			send_req(r[0], a, d, regbank_pkg::permit_t'(r[7:4]));
		end
		wait_drain("mixed traffic");

		// Withhold credits until queue and FIFO are full
		consumer_on = 1'b0;
		base = rsp_seen;
		for (int i = 0; i < STALL_READS; i++)
			send_req(1'b0, rand_addr(), '0, '0);
		idle_cycles(40);
		check_value("rsp_valid count", rsp_seen - base, RSP_CREDITS);
		check_value("request credits", up_credits, 0);
		consumer_on = 1'b1;
		wait_drain("stalled reads");

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/regbank_top.sv ====
// Top level of the banked register store, wiring dispatcher, bank array and collector to plain ports
`timescale 1ns/1ps
`default_nettype none

module regbank_top #(
	parameter int NUM_BANKS = 4,
	parameter int BANK_DEPTH = 8,
	parameter int REQ_DEPTH = 4,
	parameter int RSP_DEPTH = 4,
	parameter int RSP_CREDITS = 2
) (
	input wire clk,
	input wire rstnn,
	// Request stream
	input wire req_valid,
	input wire req_write,
	input wire regbank_pkg::addr_t req_addr,
	input wire regbank_pkg::data_t req_wdata,
	input wire regbank_pkg::permit_t req_permit,
	output wire req_credit,
	// Response stream
	output wire rsp_valid,
	output wire regbank_pkg::data_t rsp_data,
	input wire rsp_credit
);

	localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
	localparam int IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

	// Read tracking between dispatcher and collector
	wire rd_issue;
	wire [BANK_W-1:0] rd_bank;
	wire slot_free;

	// One port bundle per bank
	bank_port_if #(.IDX_W(IDX_W)) bank_ports [NUM_BANKS] ();

	// **************************************************
	// Dispatcher, banks, collector
	// **************************************************

	bank_dispatch #(
		.NUM_BANKS(NUM_BANKS),
		.BANK_DEPTH(BANK_DEPTH),
		.REQ_DEPTH(REQ_DEPTH),
		.RSP_DEPTH(RSP_DEPTH)
	) u_bank_dispatch (
		.clk(clk),
		.rstnn(rstnn),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_permit(req_permit),
		.req_credit(req_credit),
		.banks(bank_ports),
		.rd_issue(rd_issue),
		.rd_bank(rd_bank),
		.slot_free(slot_free)
	);

	for (genvar i = 0; i < NUM_BANKS; i++)
	begin : g_bank
		regfile_1r1w #(.DEPTH(BANK_DEPTH)) u_regfile (
			.clk(clk),
			.rstnn(rstnn),
			.port(bank_ports[i])
		);
	end

	read_collect #(
		.NUM_BANKS(NUM_BANKS),
		.RSP_DEPTH(RSP_DEPTH),
		.RSP_CREDITS(RSP_CREDITS)
	) u_read_collect (
		.clk(clk),
		.rstnn(rstnn),
		.banks(bank_ports),
		.rd_issue(rd_issue),
		.rd_bank(rd_bank),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.rsp_credit(rsp_credit),
		.slot_free(slot_free)
	);

endmodule

`default_nettype wire

// ==== source/read_collect.sv ====
// Read collector that selects the answering bank, queues read data and sends credited responses
`timescale 1ns/1ps
`default_nettype none

module read_collect #(
	parameter int NUM_BANKS = 4,
	parameter int RSP_DEPTH = 4,
	parameter int RSP_CREDITS = 2,
	localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
	input wire clk,
	input wire rstnn,
	bank_port_if.collect banks [NUM_BANKS],
	input wire rd_issue,
	input wire [BANK_W-1:0] rd_bank,
	output logic rsp_valid,
	output regbank_pkg::data_t rsp_data,
	input wire rsp_credit,
	output logic slot_free
);

	localparam int PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
	localparam int CNT_W = $clog2(RSP_DEPTH + 1);
	localparam int CRED_W = $clog2(RSP_CREDITS + 1);

	// Bank outputs gathered into an indexable array
	regbank_pkg::data_t bank_rdata [NUM_BANKS];

	// Issue delayed to line up with the bank's registered data
	logic issue_d;
	logic [BANK_W-1:0] bank_d;

	regbank_pkg::data_t q_data [RSP_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] q_cnt;
	logic [CRED_W-1:0] credit_cnt;
	logic push, send;

	for (genvar i = 0; i < NUM_BANKS; i++)
	begin : g_bank
		assign bank_rdata[i] = banks[i].rdata;
	end

	assign push = issue_d;
	// Head goes out only with a downstream credit in hand
	assign send = (q_cnt != '0) && (credit_cnt != '0);

	// **************************************************
	// Response queue
	// **************************************************

	always_ff @(posedge clk)
	begin
		if (push)
			q_data[wr_ptr] <= bank_rdata[bank_d];
		if (send)
			rsp_data <= q_data[rd_ptr];
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			issue_d <= 1'b0;
			bank_d <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt <= '0;
			credit_cnt <= CRED_W'(RSP_CREDITS);
			rsp_valid <= 1'b0;
			slot_free <= 1'b0;
		end
		else
		begin
			issue_d <= rd_issue;
			bank_d <= rd_bank;
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (send)
				rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, send})
				2'b10: q_cnt <= q_cnt + 1'b1;
				2'b01: q_cnt <= q_cnt - 1'b1;
				default: q_cnt <= q_cnt;
			endcase
			// Spend on send, refill on consumer pulse
			case ({send, rsp_credit})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
			rsp_valid <= send;
			// Frees one dispatcher slot per response
			slot_free <= send;
		end
	end

	// Dispatcher space count must keep the queue from overflowing
	a_queue_no_overflow: assert property (
		@(posedge clk) disable iff (!rstnn)
		push |-> ((q_cnt != CNT_W'(RSP_DEPTH)) || send)
	);

	// Consumer never returns more than it was granted
	a_credit_bound: assert property (
		@(posedge clk) disable iff (!rstnn)
		credit_cnt <= CRED_W'(RSP_CREDITS)
	);

endmodule

`default_nettype wire

// ==== source/bank_dispatch.sv ====
// Request FIFO with upstream credit return, bank decode, and read issue gated by collector space
`timescale 1ns/1ps
`default_nettype none

module bank_dispatch #(
	parameter int NUM_BANKS = 4,
	parameter int BANK_DEPTH = 8,
	parameter int REQ_DEPTH = 4,
	parameter int RSP_DEPTH = 4,
	localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
	input wire clk,
	input wire rstnn,
	input wire req_valid,
	input wire req_write,
	input wire regbank_pkg::addr_t req_addr,
	input wire regbank_pkg::data_t req_wdata,
	input wire regbank_pkg::permit_t req_permit,
	output logic req_credit,
	bank_port_if.dispatch banks [NUM_BANKS],
	output logic rd_issue,
	output logic [BANK_W-1:0] rd_bank,
	input wire slot_free
);

	localparam int IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
	localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(REQ_DEPTH + 1);
	localparam int SPACE_W = $clog2(RSP_DEPTH + 1);

	// Request FIFO payload
	logic fifo_write [REQ_DEPTH];
	regbank_pkg::addr_t fifo_addr [REQ_DEPTH];
	regbank_pkg::data_t fifo_wdata [REQ_DEPTH];
	regbank_pkg::permit_t fifo_permit [REQ_DEPTH];

	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] fifo_cnt;
	// Free collector slots
	logic [SPACE_W-1:0] space_cnt;

	logic head_write;
	regbank_pkg::addr_t head_addr;
	logic [BANK_W-1:0] head_bank;
	logic [IDX_W-1:0] head_idx;
	logic pop;

	// **************************************************
	// Head decode
	// **************************************************

	assign head_write = fifo_write[rd_ptr];
	assign head_addr = fifo_addr[rd_ptr];
	// Low bits pick the bank, the rest pick the entry
	assign head_bank = BANK_W'(head_addr % NUM_BANKS);
	assign head_idx = IDX_W'(head_addr / NUM_BANKS);

	// Writes always go, reads need a reserved collector slot
	assign pop = (fifo_cnt != '0) && (head_write || (space_cnt != '0));
	assign rd_issue = pop && !head_write;
	assign rd_bank = head_bank;

	// Per-bank strobes
	// Data and index are broadcast
	for (genvar i = 0; i < NUM_BANKS; i++)
	begin : g_bank
		assign banks[i].wenable = pop && head_write && (head_bank == BANK_W'(i));
		assign banks[i].windex = head_idx;
		assign banks[i].wpermit = fifo_permit[rd_ptr];
		assign banks[i].wdata = fifo_wdata[rd_ptr];
		assign banks[i].renable = rd_issue && (head_bank == BANK_W'(i));
		assign banks[i].rindex = head_idx;
	end

	// Capture at the edge where req_valid is seen
	always_ff @(posedge clk)
	begin
		if (req_valid)
		begin
			fifo_write[wr_ptr] <= req_write;
			fifo_addr[wr_ptr] <= req_addr;
			fifo_wdata[wr_ptr] <= req_wdata;
			fifo_permit[wr_ptr] <= req_permit;
		end
	end

	// **************************************************
	// Pointers, occupancy, credits
	// **************************************************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			space_cnt <= SPACE_W'(RSP_DEPTH);
			req_credit <= 1'b0;
		end
		else
		begin
			if (req_valid)
				wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({req_valid, pop})
				2'b10: fifo_cnt <= fifo_cnt + 1'b1;
				2'b01: fifo_cnt <= fifo_cnt - 1'b1;
				default: fifo_cnt <= fifo_cnt;
			endcase
			// Slot reserved on issue, returned on send
			case ({rd_issue, slot_free})
				2'b10: space_cnt <= space_cnt - 1'b1;
				2'b01: space_cnt <= space_cnt + 1'b1;
				default: space_cnt <= space_cnt;
			endcase
			// One upstream credit per pop
			req_credit <= pop;
		end
	end

	// Upstream only sends while holding a credit
	a_no_req_when_full: assert property (
		@(posedge clk) disable iff (!rstnn)
		req_valid |-> (fifo_cnt != CNT_W'(REQ_DEPTH))
	);

endmodule

`default_nettype wire

// ==== source/regfile_1r1w.sv ====
// One register-file bank with a byte-permit write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

module regfile_1r1w #(
	parameter int DEPTH = 8
) (
	input wire clk,
	input wire rstnn,
	bank_port_if.bank port
);

	// **************************************************
	// Storage
	// **************************************************

	// Entry array, cleared by reset
	regbank_pkg::data_t mem [DEPTH];

	// Write port
	// Only bytes with a set permit bit change
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			for (int e = 0; e < DEPTH; e++)
			begin
				mem[e] <= '0;
			end
		end
		else if (port.wenable)
		begin
			for (int b = 0; b < regbank_pkg::PERMIT_W; b++)
			begin
				// Byte lane b
				if (port.wpermit[b])
				begin
					mem[port.windex][b*regbank_pkg::SUBWORD_W +: regbank_pkg::SUBWORD_W] <=
						port.wdata[b*regbank_pkg::SUBWORD_W +: regbank_pkg::SUBWORD_W];
				end
			end
		end
	end

	// **************************************************
	// Read port
	// **************************************************

	// Registered read
	// Output holds its value between reads
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			port.rdata <= '0;
		end
		else if (port.renable)
		begin
			// Write from an earlier pop is already in mem
			port.rdata <= mem[port.rindex];
		end
	end

	// **************************************************
	// Checks
	// **************************************************

	// Dispatcher decode must stay inside this bank
	a_windex_range: assert property (
		@(posedge clk) disable iff (!rstnn)
		port.wenable |-> (int'(port.windex) < DEPTH)
	);

endmodule

`default_nettype wire

// ==== source/bank_port_if.sv ====
// Per-bank port bundle linking the dispatcher, one register-file bank and the read collector
`timescale 1ns/1ps
`default_nettype none

interface bank_port_if #(
	parameter int IDX_W = 3
);

	// Write side, permit-masked
	logic wenable;
	logic [IDX_W-1:0] windex;
	regbank_pkg::permit_t wpermit;
	regbank_pkg::data_t wdata;

	// Read side, data registered inside the bank
	logic renable;
	logic [IDX_W-1:0] rindex;
	regbank_pkg::data_t rdata;

	// Dispatcher owns all strobes and indexes
	modport dispatch (output wenable, windex, wpermit, wdata, renable, rindex);

	// Bank consumes the strobes and returns read data
	modport bank (input wenable, windex, wpermit, wdata, renable, rindex, output rdata);

	// Collector only samples read data
	modport collect (input rdata);

endinterface

`default_nettype wire

// ==== source/regbank_pkg.sv ====
// Shared data, permit and address widths for the banked register store, referenced by scoped name
`default_nettype none

package regbank_pkg;

	// **************************************************
	// Fixed widths
	// **************************************************

	// One data word
	localparam int DATA_W = 32;

	// One permit unit, a byte
	localparam int SUBWORD_W = 8;

	// Subwords per word, one permit bit each
	localparam int PERMIT_W = DATA_W / SUBWORD_W;

	// Request address, bank bits low and entry bits above
	localparam int ADDR_W = 8;

	// **************************************************
	// Types
	// **************************************************

	// Whole word as stored and returned
	typedef logic [DATA_W-1:0] data_t;

	// Bit k enables byte k of a write
	typedef logic [PERMIT_W-1:0] permit_t;

	// Request address
	typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire
